/* include/ascii_codes.svh */
////////////////////////////////////////////////////////////
// Control codes seen by the console writer
// Only the codes that the writer acts on are listed here
// Blank is code zero, the value that fills and clears use
////////////////////////////////////////////////////////////

`ifndef ASCII_CODES_SVH
`define ASCII_CODES_SVH

// Horizontal tab, writes a run of blanks
`define ASCII_HT     8'h09
`define ASCII_LF     8'h0A   // Line feed
`define ASCII_CR     8'h0D   // Carriage return

// Ignored unless alternate mode is on
`define ASCII_DEL    8'h7F

// First printable code
`define ASCII_SPACE  8'h20

// Stored by fills and by the screen clear
`define ASCII_BLANK  8'h00

`endif

/* source/console_pkg.sv */
////////////////////////////////////////////////////////////
// Geometry and shared types of the console buffer
// The buffer holds exactly one screen, no scrolling
// An address is {row, col}, so text_cols must be 2**4
// and text_rows must be 2**2 for the row and col types
////////////////////////////////////////////////////////////

package console_pkg;

  localparam int text_cols   = 16;  // Characters per row
  localparam int text_rows   = 4;   // Rows per screen
  localparam int font_height = 2;   // Font lines per text row
  localparam int screen_size = text_cols * text_rows;
  localparam int addr_w      = 6;   // Covers screen_size

  typedef logic [7:0]        char_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [3:0]        col_t;
  typedef logic [1:0]        row_t;
  typedef logic [0:0]        font_line_t;
  typedef logic [2:0]        tab_count_t;

  // One RAM write, presented for a single cycle
  typedef struct packed {
    logic  en;
    addr_t addr;
    char_t data;
  } char_wr_t;

  // Writer states
  typedef enum logic [2:0] {
    wr_idle,
    wr_put_char,      // Store one code, then advance
    wr_fill_line,     // Blanks up to end of row
    wr_fill_tab,      // Latched number of blanks
    wr_clear_screen   // All addresses, cursor home
  } wr_state_e;

  // Frame reader states
  typedef enum logic [2:0] {
    rd_idle,
    rd_wait_writer,   // Hold off until the writer is done
    rd_settle,        // RAM read latency
    rd_get_char,      // Waits here for the request enable
    rd_get_gap
  } rd_state_e;

endpackage

/* source/char_ram.sv */
////////////////////////////////////////////////////////////
// Screen storage, one write port and one read port
// Read data is registered, one cycle after the address
// No reset, contents are undefined until the first clear
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module char_ram (
  input  logic                  clk,
  input  console_pkg::char_wr_t i_wr,
  input  console_pkg::addr_t    i_rd_addr,
  output console_pkg::char_t    o_rd_data
);

  console_pkg::char_t mem [console_pkg::screen_size];

  always_ff @(posedge clk) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // Old data on a same-address collision
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* source/char_writer.sv */
////////////////////////////////////////////////////////////
// Character writer with a row/column cursor
// Accepts a code only while o_wr_char_rdy is high
// Clear requests are latched and wait for the reader
// HT with a tab count of zero is ignored
// Cursor wraps from the last row back to row 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ascii_codes.svh"

module char_writer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_alt_func_en,
  input  logic                    i_clear_screen_stb,
  input  console_pkg::tab_count_t i_tab_count,
  input  logic                    i_char_stb,
  input  console_pkg::char_t      i_char,
  input  logic                    i_rd_busy,
  output logic                    o_wr_char_rdy,
  output logic                    o_wr_busy,
  output console_pkg::char_wr_t   o_wr
);

  console_pkg::wr_state_e  state;
  console_pkg::row_t       row;
  console_pkg::col_t       col;
  console_pkg::row_t       row_nxt;
  console_pkg::row_t       row_adv;
  console_pkg::col_t       col_nxt;
  console_pkg::tab_count_t tab_left;
  logic                    last_col;
  logic                    clear_pending;
  logic                    printable;

  // Cursor stepping, shared by characters and tab blanks
  assign last_col = (col == console_pkg::col_t'(console_pkg::text_cols - 1));
  assign col_nxt  = last_col ? '0 : col + 1'b1;
  assign row_nxt  = (row == console_pkg::row_t'(console_pkg::text_rows - 1)) ?
                    '0 : row + 1'b1;
  assign row_adv  = last_col ? row_nxt : row;

  assign printable = (i_char >= `ASCII_SPACE) && (i_char != `ASCII_DEL);

  assign o_wr_busy     = (state != console_pkg::wr_idle);
  assign o_wr_char_rdy = (state == console_pkg::wr_idle) && !clear_pending && !i_rd_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= console_pkg::wr_clear_screen;  // Blank screen out of reset
      row           <= '0;
      col           <= '0;
      tab_left      <= '0;
      clear_pending <= 1'b0;
      o_wr          <= '{en: 1'b1, addr: '0, data: `ASCII_BLANK};
    end else begin
      case (state)
        console_pkg::wr_idle: begin
          if (!i_rd_busy && clear_pending) begin
            clear_pending <= 1'b0;
            row           <= '0;
            col           <= '0;
            o_wr          <= '{en: 1'b1, addr: '0, data: `ASCII_BLANK};
            state         <= console_pkg::wr_clear_screen;
          end else if (!i_rd_busy && i_char_stb) begin
            if (i_alt_func_en || printable) begin
              // Stored as it comes
              o_wr  <= '{en: 1'b1, addr: {row, col}, data: i_char};
              state <= console_pkg::wr_put_char;
            end else begin
              case (i_char)
                `ASCII_HT: begin
                  if (i_tab_count != '0) begin
                    tab_left <= i_tab_count;
                    o_wr     <= '{en: 1'b1, addr: {row, col}, data: `ASCII_BLANK};
                    state    <= console_pkg::wr_fill_tab;
                  end
                end
                `ASCII_CR, `ASCII_LF: begin
                  o_wr  <= '{en: 1'b1, addr: {row, col}, data: `ASCII_BLANK};
                  state <= console_pkg::wr_fill_line;
                end
                default: begin
                  // Other control codes and DEL do nothing
                end
              endcase
            end
          end
        end

        console_pkg::wr_put_char: begin
          row     <= row_adv;
          col     <= col_nxt;
          o_wr.en <= 1'b0;
          state   <= console_pkg::wr_idle;
        end

        console_pkg::wr_fill_line: begin
          if (last_col) begin
            // Row done, cursor to start of next row
            row     <= row_nxt;
            col     <= '0;
            o_wr.en <= 1'b0;
            state   <= console_pkg::wr_idle;
          end else begin
            col       <= col_nxt;
            o_wr.addr <= {row, col_nxt};
          end
        end

        console_pkg::wr_fill_tab: begin
          row <= row_adv;
          col <= col_nxt;
          if (tab_left == console_pkg::tab_count_t'(1)) begin
            o_wr.en <= 1'b0;
            state   <= console_pkg::wr_idle;
          end else begin
            tab_left  <= tab_left - 1'b1;
            o_wr.addr <= {row_adv, col_nxt};
          end
        end

        console_pkg::wr_clear_screen: begin
          if (o_wr.addr == console_pkg::addr_t'(console_pkg::screen_size - 1)) begin
            o_wr.en <= 1'b0;
            state   <= console_pkg::wr_idle;
          end else begin
            o_wr.addr <= o_wr.addr + 1'b1;  // One blank per cycle
          end
        end

        default: begin
          o_wr.en <= 1'b0;
          state   <= console_pkg::wr_idle;
        end
      endcase

      // A new request during a clear is kept for later
      if (i_clear_screen_stb) begin
        clear_pending <= 1'b1;
      end
    end
  end

endmodule

/* source/frame_reader.sv */
////////////////////////////////////////////////////////////
// Frame scan for the font renderer
// Each text row is sent once per font line
// One character per request enable, then a gap cycle
// Frame strobes during a scan are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_reader (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_read_frame_stb,
  input  logic               i_char_req_en,
  input  logic               i_wr_busy,
  output logic               o_rd_busy,
  output console_pkg::addr_t o_rd_addr,
  output logic               o_char_rdy
);

  console_pkg::rd_state_e  state;
  console_pkg::col_t       col;
  console_pkg::font_line_t fline;
  console_pkg::row_t       row;
  logic                    last_col;
  logic                    last_fline;
  logic                    last_row;
  logic                    frame_end;

  assign last_col   = (col == console_pkg::col_t'(console_pkg::text_cols - 1));
  assign last_fline = (fline == console_pkg::font_line_t'(console_pkg::font_height - 1));
  assign last_row   = (row == console_pkg::row_t'(console_pkg::text_rows - 1));

  // Font line does not take part in the address
  assign o_rd_addr = {row, col};
  assign o_rd_busy = (state != console_pkg::rd_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= console_pkg::rd_idle;
      col        <= '0;
      fline      <= '0;
      row        <= '0;
      frame_end  <= 1'b0;
      o_char_rdy <= 1'b0;
    end else begin
      o_char_rdy <= 1'b0;
      case (state)
        console_pkg::rd_idle: begin
          col       <= '0;
          fline     <= '0;
          row       <= '0;
          frame_end <= 1'b0;
          if (i_read_frame_stb) begin
            state <= console_pkg::rd_wait_writer;
          end
        end

        console_pkg::rd_wait_writer: begin
          if (!i_wr_busy) begin
            state <= console_pkg::rd_settle;
          end
        end

        console_pkg::rd_settle: state <= console_pkg::rd_get_char;

        console_pkg::rd_get_char: begin
          if (i_char_req_en) begin
            // RAM output holds the current char through the gap
            o_char_rdy <= 1'b1;
            frame_end  <= last_col && last_fline && last_row;
            col        <= last_col ? '0 : col + 1'b1;
            if (last_col) begin
              fline <= last_fline ? '0 : fline + 1'b1;
              if (last_fline) begin
                row <= last_row ? '0 : row + 1'b1;  // Next text row
              end
            end
            state <= console_pkg::rd_get_gap;
          end
        end

        console_pkg::rd_get_gap: begin
          state <= frame_end ? console_pkg::rd_idle : console_pkg::rd_get_char;
        end

        default: state <= console_pkg::rd_idle;
      endcase
    end
  end

endmodule

/* source/console_char_buffer.sv */
////////////////////////////////////////////////////////////
// Console character buffer, top level
// Writer and reader share one RAM and take turns
// o_char comes straight from the RAM read register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module console_char_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_alt_func_en,
  input  logic                    i_clear_screen_stb,
  input  console_pkg::tab_count_t i_tab_count,
  input  logic                    i_char_stb,
  input  console_pkg::char_t      i_char,
  output logic                    o_wr_char_rdy,
  input  logic                    i_read_frame_stb,
  input  logic                    i_char_req_en,
  output logic                    o_char_rdy,
  output console_pkg::char_t      o_char
);

  console_pkg::char_wr_t wr;
  console_pkg::addr_t    rd_addr;
  logic                  wr_busy;
  logic                  rd_busy;

  char_writer char_writer_i (
    .clk                (clk),
    .rst                (rst),
    .i_alt_func_en      (i_alt_func_en),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_tab_count        (i_tab_count),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_rd_busy          (rd_busy),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .o_wr_busy          (wr_busy),
    .o_wr               (wr)
  );

  frame_reader frame_reader_i (
    .clk              (clk),
    .rst              (rst),
    .i_read_frame_stb (i_read_frame_stb),
    .i_char_req_en    (i_char_req_en),
    .i_wr_busy        (wr_busy),
    .o_rd_busy        (rd_busy),
    .o_rd_addr        (rd_addr),
    .o_char_rdy       (o_char_rdy)
  );

  char_ram char_ram_i (
    .clk       (clk),
    .i_wr      (wr),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_char)
  );

endmodule

/* bench/console_checker.sv */
////////////////////////////////////////////////////////////
// Reference model of the screen and cursor
// Codes are applied when accepted, clears once no scan runs
// Assumes no character strobe in the same cycle as a clear
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ascii_codes.svh"

module console_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_alt_func_en,
  input  logic                    i_clear_screen_stb,
  input  console_pkg::tab_count_t i_tab_count,
  input  logic                    i_char_stb,
  input  console_pkg::char_t      i_char,
  input  logic                    i_wr_char_rdy,
  input  logic                    i_read_frame_stb,
  input  logic                    i_char_rdy,
  input  console_pkg::char_t      i_read_char,
  output int                      o_error_count,
  output int                      o_frame_count,
  output int                      o_char_count
);

  localparam int line_pulses  = console_pkg::text_cols * console_pkg::font_height;
  localparam int frame_pulses = line_pulses * console_pkg::text_rows;

  console_pkg::char_t screen [console_pkg::screen_size];
  int   cur_row;
  int   cur_col;
  int   pulses;          // Pulses seen in this frame
  logic frame_active;
  logic was_active;
  logic clear_pending;   // Held until the scan is over

  function automatic console_pkg::addr_t addr_of(input int row, input int col);
    return console_pkg::addr_t'(row * console_pkg::text_cols + col);
  endfunction

  task automatic put_code(input console_pkg::char_t code);
    screen[addr_of(cur_row, cur_col)] = code;
    cur_col = cur_col + 1;
    if (cur_col == console_pkg::text_cols) begin
      cur_col = 0;
      cur_row = (cur_row + 1) % console_pkg::text_rows;  // Wraps to row 0
    end
  endtask

  task automatic apply_code(input console_pkg::char_t code, input logic alt,
                            input console_pkg::tab_count_t tab);
    int n;
    if (alt || (code >= `ASCII_SPACE && code != `ASCII_DEL)) begin
      put_code(code);
    end else if (code == `ASCII_HT) begin
      for (n = 0; n < int'(tab); n++) begin
        put_code(`ASCII_BLANK);
      end
    end else if (code == `ASCII_CR || code == `ASCII_LF) begin
      for (n = cur_col; n < console_pkg::text_cols; n++) begin
        screen[addr_of(cur_row, n)] = `ASCII_BLANK;
      end
      cur_col = 0;
      cur_row = (cur_row + 1) % console_pkg::text_rows;
    end
  endtask

  task automatic clear_model;
    int n;
    for (n = 0; n < console_pkg::screen_size; n++) begin
      screen[console_pkg::addr_t'(n)] = `ASCII_BLANK;
    end
    cur_row = 0;
    cur_col = 0;
  endtask

  // Scan order is row, then font line, then column
  task automatic check_pulse;
    int                 row;
    int                 fline;
    int                 col;
    console_pkg::char_t expected;
    row      = pulses / line_pulses;
    fline    = (pulses / console_pkg::text_cols) % console_pkg::font_height;
    col      = pulses % console_pkg::text_cols;
    expected = screen[addr_of(row, col)];
    if (i_read_char !== expected) begin
      o_error_count++;
      $display("error: o_char at row %0d font line %0d col %0d is %h, expected %h",
               row, fline, col, i_read_char, expected);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      clear_model();
      frame_active  = 1'b0;
      clear_pending = 1'b0;
      pulses        = 0;
      o_error_count = 0;
      o_frame_count = 0;
      o_char_count  = 0;
    end else begin
      was_active = frame_active;
      if (i_char_rdy && !was_active) begin
        o_error_count++;
        $display("A character pulse came while no frame read was in progress");
      end else if (i_char_rdy) begin
        check_pulse();
        pulses++;
        if (pulses == frame_pulses) begin
          frame_active = 1'b0;
          o_frame_count++;
        end
      end
      if (was_active && i_wr_char_rdy) begin
        o_error_count++;
        $display("The writer was ready after only %0d pulses of a frame", pulses);
        frame_active = 1'b0;  // Resync on the short frame
      end
      if (i_char_stb && i_wr_char_rdy) begin
        apply_code(i_char, i_alt_func_en, i_tab_count);
        o_char_count++;
      end
      if (i_clear_screen_stb) begin
        clear_pending = 1'b1;
      end
      if (clear_pending && !was_active) begin
        clear_model();
        clear_pending = 1'b0;
      end
      if (i_read_frame_stb && !was_active) begin
        frame_active = 1'b1;
        pulses       = 0;
      end
    end
  end

endmodule

/* bench/console_assert.sv */
////////////////////////////////////////////////////////////
// Port rules of the console buffer, bound to its top level
// Covers the read pulse spacing and the ready exclusion
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module console_assert (
  input logic clk,
  input logic rst,
  input logic i_char_rdy,
  input logic i_wr_char_rdy
);

  int fail_count = 0;

  // A gap cycle follows every pulse
  pulse_gap: assert property (@(posedge clk) disable iff (rst)
                              i_char_rdy |=> !i_char_rdy)
    else begin
      fail_count++;
      $error("o_char_rdy was high in two consecutive cycles");
    end

  // Writer is locked out while the reader scans
  ready_excl: assert property (@(posedge clk) disable iff (rst)
                               i_char_rdy |-> !i_wr_char_rdy)
    else begin
      fail_count++;
      $error("o_char_rdy and o_wr_char_rdy were high together");
    end

  reset_quiet: assert property (@(posedge clk) rst |=> !i_char_rdy)
    else begin
      fail_count++;
      $error("o_char_rdy was high in the cycle after reset");
    end

endmodule

bind console_char_buffer console_assert console_assert_i (
  .clk           (clk),
  .rst           (rst),
  .i_char_rdy    (o_char_rdy),
  .i_wr_char_rdy (o_wr_char_rdy)
);

/* bench/tb_console.sv */
////////////////////////////////////////////////////////////
// Testbench for the console character buffer
// Inputs change on the falling edge
// Random data comes from a fixed seed
// Every wait gives up after its own cycle limit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ascii_codes.svh"

module tb_console;

  localparam int ready_limit = 300;   // Longest writer job is the clear
  localparam int frame_limit = 5000;

  logic                    clk;
  logic                    rst;
  logic                    i_alt_func_en;
  logic                    i_clear_screen_stb;
  console_pkg::tab_count_t i_tab_count;
  logic                    i_char_stb;
  console_pkg::char_t      i_char;
  logic                    o_wr_char_rdy;
  logic                    i_read_frame_stb;
  logic                    i_char_req_en;
  logic                    o_char_rdy;
  console_pkg::char_t      o_char;
  integer                  seed;
  logic                    req_always;  // Request enable pinned high
  logic                    timed_out;
  int                      error_count;
  int                      frame_count;
  int                      char_count;
  int                      assert_fails;
  int                      i;

  console_char_buffer console_char_buffer_i (.*);

  console_checker console_checker_i (
    .clk                (clk),
    .rst                (rst),
    .i_alt_func_en      (i_alt_func_en),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_tab_count        (i_tab_count),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_wr_char_rdy      (o_wr_char_rdy),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_rdy         (o_char_rdy),
    .i_read_char        (o_char),
    .o_error_count      (error_count),
    .o_frame_count      (frame_count),
    .o_char_count       (char_count)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic console_pkg::char_t to_printable(input logic [31:0] r);
    return 8'h20 + (r[7:0] % 8'd95);
  endfunction

  // Strobes last one cycle and the request enable is redrawn each cycle
  task automatic next_cycle;
    logic [31:0] r;
    @(negedge clk);
    i_char_stb         = 1'b0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    r                  = $random(seed);
    i_char_req_en      = req_always || (r[1:0] != 2'b00);
  endtask

  task automatic wait_ready;
    int count;
    count = 0;
    while (!timed_out && !o_wr_char_rdy && count < ready_limit) begin
      next_cycle();
      count++;
    end
    if (!timed_out && !o_wr_char_rdy) begin
      timed_out = 1'b1;
      $display("Timeout: the writer was not ready within %0d cycles", ready_limit);
    end
  endtask

  task automatic send_char(input console_pkg::char_t code, input logic alt,
                           input console_pkg::tab_count_t tab);
    wait_ready();
    if (timed_out) return;
    i_char        = code;
    i_alt_func_en = alt;
    i_tab_count   = tab;
    i_char_stb    = 1'b1;
    next_cycle();
  endtask

  task automatic clear_screen;
    wait_ready();
    if (timed_out) return;
    i_clear_screen_stb = 1'b1;
    next_cycle();
  endtask

  // Mid-scan clear, second frame strobe and lost character strobes
  task automatic read_frame(input logic rand_req, input int clear_at,
                            input int restrobe_at, input logic poke);
    int          count;
    int          start;
    logic [31:0] r;
    wait_ready();
    if (timed_out) return;
    req_always       = !rand_req;
    start            = frame_count;
    i_read_frame_stb = 1'b1;
    count            = 0;
    next_cycle();
    while (frame_count == start && count < frame_limit) begin
      r = $random(seed);
      if (count == clear_at) begin
        i_clear_screen_stb = 1'b1;
      end else if (count == restrobe_at) begin
        i_read_frame_stb = 1'b1;
      end else if (poke && r[3:0] == 4'h0) begin
        i_char     = r[11:4];
        i_char_stb = 1'b1;
      end
      next_cycle();
      count++;
    end
    req_always = 1'b1;
    if (frame_count == start) begin
      timed_out = 1'b1;
      $display("Timeout: a frame read did not finish within %0d cycles", frame_limit);
    end
  endtask

  task automatic random_burst(input int n);
    logic [31:0]        r;
    console_pkg::char_t code;
    int                 k;
    for (k = 0; k < n; k++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    code = r[3] ? `ASCII_CR : `ASCII_LF;
        3'd1:    code = `ASCII_HT;
        3'd2:    code = {3'b000, r[12:8]};  // Control range
        default: code = to_printable({8'h00, r[31:8]});
      endcase
      send_char(code, r[23:21] == 3'b000, r[18:16]);
    end
  endtask

  initial begin
    seed               = 9623;
    rst                = 1'b1;
    i_alt_func_en      = 1'b0;
    i_clear_screen_stb = 1'b0;
    i_tab_count        = '0;
    i_char_stb         = 1'b0;
    i_char             = '0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b0;
    req_always         = 1'b1;
    timed_out          = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    read_frame(1'b0, -1, -1, 1'b0);  // Blank screen out of reset
    for (i = 0; i < 70; i++) begin
      send_char(to_printable($random(seed)), 1'b0, 3'd0);
    end
    read_frame(1'b0, -1, -1, 1'b0);

    // Line ends mid-row and at column 0, then tabs
    send_char(8'h41, 1'b0, 3'd0);
    send_char(`ASCII_CR, 1'b0, 3'd0);
    send_char(`ASCII_LF, 1'b0, 3'd0);
    send_char(8'h42, 1'b0, 3'd0);
    send_char(`ASCII_HT, 1'b0, 3'd5);
    send_char(8'h43, 1'b0, 3'd0);
    send_char(`ASCII_HT, 1'b0, 3'd0);
    send_char(`ASCII_HT, 1'b0, 3'd7);
    send_char(8'h44, 1'b0, 3'd0);
    read_frame(1'b0, -1, -1, 1'b0);

    // Raw codes in alternate mode, then ignored codes
    for (i = 0; i < 20; i++) begin
      send_char(8'(i), 1'b1, 3'd2);
    end
    send_char(`ASCII_DEL, 1'b1, 3'd0);
    send_char(8'h01, 1'b0, 3'd0);
    send_char(8'h1B, 1'b0, 3'd0);
    send_char(`ASCII_DEL, 1'b0, 3'd0);
    send_char(8'h00, 1'b0, 3'd0);
    read_frame(1'b0, -1, -1, 1'b0);

    // Clear while idle, then during a scan
    clear_screen();
    send_char(8'h5A, 1'b0, 3'd0);
    read_frame(1'b0, -1, -1, 1'b0);
    random_burst(20);
    read_frame(1'b1, 60, -1, 1'b0);
    send_char(8'h51, 1'b0, 3'd0);
    read_frame(1'b0, -1, -1, 1'b0);

    for (i = 0; i < 6; i++) begin
      random_burst(30 + 5 * i);
      read_frame(1'b1, (i == 3) ? 200 : -1, 25, 1'b1);
    end

    assert_fails = console_char_buffer_i.console_assert_i.fail_count;
    $display("Errors %0d, assertion failures %0d, timeouts %0d, frames %0d, characters %0d",
             error_count, assert_fails, timed_out, frame_count, char_count);
    if (error_count == 0 && assert_fails == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
source/console_pkg.sv
source/char_ram.sv
source/char_writer.sv
source/frame_reader.sv
source/console_char_buffer.sv
bench/console_checker.sv
bench/console_assert.sv
bench/tb_console.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_console -f compile.f \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vtb_console +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log && echo "Simulation PASSED" \
  || { echo "Simulation ended without a result"; exit 1; }
